// ==== src/bridge_macros.svh ====
// --------------------------------------------------
// widths and depths shared by RTL and testbench.
// BRIDGE_BID_DEPTH must be a power of two.
// --------------------------------------------------
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// AXI side widths.
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32
`define BRIDGE_ID_W 4

// memory size in 32-bit words.
`define BRIDGE_MEM_WORDS 256

// outstanding write responses before AW and W stall.
`define BRIDGE_BID_DEPTH 4

`endif

// ==== src/axi_pkg.sv ====
// --------------------------------------------------
// AXI slave port types, INCR bursts of 32-bit beats only.
// --------------------------------------------------
`include "bridge_macros.svh"

package axi_pkg;

  typedef logic [`BRIDGE_ADDR_W-1:0]   addr_t;
  typedef logic [`BRIDGE_DATA_W-1:0]   data_t;
  typedef logic [`BRIDGE_DATA_W/8-1:0] strb_t;
  typedef logic [`BRIDGE_ID_W-1:0]     id_t;
  // beats minus one, so at most 16 beats.
  typedef logic [3:0]                  len_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_e;

  // --------------------------------------------------
  // channel payloads
  // --------------------------------------------------
  typedef struct packed {id_t id; addr_t addr; len_t len;} ax_t;

  typedef struct packed {data_t data; strb_t strb; logic last;} w_t;

  typedef struct packed {id_t id; data_t data; resp_e resp; logic last;} r_t;

  typedef struct packed {id_t id; resp_e resp;} b_t;

endpackage

// ==== src/corebus_pkg.sv ====
// --------------------------------------------------
// internal command bus types. Addresses are byte
// addresses with the low two bits cleared.
// --------------------------------------------------
package corebus_pkg;

  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } cmd_e;

  // beat count, 1 to 16.
  typedef logic [4:0] length_t;

  typedef struct packed {
    cmd_e          kind;
    axi_pkg::id_t   id;
    axi_pkg::addr_t addr;
    length_t       length;
  } cmd_t;

  typedef struct packed {
    axi_pkg::data_t data;
    axi_pkg::strb_t byteen;
    logic          last;
  } wdata_t;

  // error marks a beat read from outside the memory.
  typedef struct packed {
    axi_pkg::id_t   id;
    axi_pkg::data_t data;
    logic          error;
    logic          last;
  } resp_t;

endpackage

// ==== src/axi_cmd_decode.sv ====
// --------------------------------------------------
// AR/AW to command conversion with a one-entry slot.
// --------------------------------------------------
`timescale 1ns/100ps

module axi_cmd_decode (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_ar_valid,
  output logic               o_ar_ready,
  input  axi_pkg::ax_t       i_ar,
  input  logic               i_aw_valid,
  output logic               o_aw_ready,
  input  axi_pkg::ax_t       i_aw,
  input  logic               i_aw_block,
  output logic               o_aw_fire,
  output logic               o_cmd_valid,
  input  logic               i_cmd_ready,
  output corebus_pkg::cmd_t  o_cmd
);

  logic              init_q;
  logic              slot_valid_q;
  corebus_pkg::cmd_t slot_q;
  logic              rr_aw_q;
  logic              slot_free;
  logic              aw_req;
  logic              grant_ar;
  logic              grant_aw;
  corebus_pkg::cmd_t next_cmd;

  function automatic corebus_pkg::cmd_t to_cmd(corebus_pkg::cmd_e kind, axi_pkg::ax_t ax);
    corebus_pkg::cmd_t cmd;
    cmd.kind   = kind;
    cmd.id     = ax.id;
    cmd.addr   = {ax.addr[$bits(axi_pkg::addr_t)-1:2], 2'b00};
    cmd.length = corebus_pkg::length_t'(ax.len) + corebus_pkg::length_t'(1);
    return cmd;
  endfunction

  // the slot refills in the same cycle that it drains.
  always_comb begin
    slot_free  = init_q && (!slot_valid_q || i_cmd_ready);
    aw_req     = i_aw_valid && !i_aw_block;
    grant_aw   = aw_req && (!i_ar_valid || rr_aw_q);
    grant_ar   = i_ar_valid && !grant_aw;
    next_cmd   = grant_aw ? to_cmd(corebus_pkg::CMD_WRITE, i_aw)
                          : to_cmd(corebus_pkg::CMD_READ, i_ar);
    o_ar_ready = slot_free && grant_ar;
    o_aw_ready = slot_free && grant_aw;
    o_aw_fire  = i_aw_valid && o_aw_ready;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      init_q       <= 1'b0;
      slot_valid_q <= 1'b0;
      rr_aw_q      <= 1'b0;
    end else begin
      init_q <= 1'b1;
      if (slot_free) begin
        slot_valid_q <= grant_ar || grant_aw;
      end
      // the winner drops to the lower priority.
      if (slot_free && grant_ar) begin
        rr_aw_q <= 1'b1;
      end else if (slot_free && grant_aw) begin
        rr_aw_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (slot_free && (grant_ar || grant_aw)) begin
      slot_q <= next_cmd;
    end
  end

  assign o_cmd_valid = slot_valid_q;
  assign o_cmd       = slot_q;

  // an address command that waits for the slot keeps its payload.
  a_ar_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_ar_valid && !o_ar_ready) |=> (i_ar_valid && $stable(i_ar)));

  a_aw_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_aw_valid && !o_aw_ready) |=> (i_aw_valid && $stable(i_aw)));

endmodule

// ==== src/corebus_mem_target.sv ====
// --------------------------------------------------
// single-port word memory, one command at a time.
// Out-of-range writes are dropped without an error.
// --------------------------------------------------
`timescale 1ns/100ps
`include "bridge_macros.svh"

module corebus_mem_target (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_cmd_valid,
  output logic                 o_cmd_ready,
  input  corebus_pkg::cmd_t    i_cmd,
  input  logic                 i_wdata_valid,
  output logic                 o_wdata_ready,
  input  corebus_pkg::wdata_t  i_wdata,
  output logic                 o_resp_valid,
  input  logic                 i_resp_ready,
  output corebus_pkg::resp_t   o_resp
);

  localparam int WORD_W = `BRIDGE_ADDR_W - 2;
  localparam int IDX_W  = $clog2(`BRIDGE_MEM_WORDS);
  localparam int STRB_W = `BRIDGE_DATA_W / 8;
  localparam logic [WORD_W-1:0] MEM_LIMIT = WORD_W'(`BRIDGE_MEM_WORDS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WRITE
  } state_e;

  state_e                state_q;
  corebus_pkg::length_t  remain_q;
  axi_pkg::id_t          id_q;
  logic [WORD_W-1:0]     word_q;
  logic [`BRIDGE_DATA_W-1:0] mem [`BRIDGE_MEM_WORDS];
  logic                  cmd_fire;
  logic                  rd_fire;
  logic                  wr_fire;
  logic                  in_range;
  logic [IDX_W-1:0]      mem_idx;

  always_comb begin
    o_cmd_ready   = (state_q == ST_IDLE);
    o_wdata_ready = (state_q == ST_WRITE);
    o_resp_valid  = (state_q == ST_READ);
    cmd_fire      = i_cmd_valid && o_cmd_ready;
    rd_fire       = o_resp_valid && i_resp_ready;
    wr_fire       = i_wdata_valid && o_wdata_ready;
    in_range      = word_q < MEM_LIMIT;
    mem_idx       = word_q[IDX_W-1:0];
  end

  always_comb begin
    o_resp.id    = id_q;
    o_resp.data  = in_range ? mem[mem_idx] : '0;
    o_resp.error = !in_range;
    o_resp.last  = (remain_q == corebus_pkg::length_t'(1));
  end

  // --------------------------------------------------
  // command FSM
  // --------------------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q  <= ST_IDLE;
      remain_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (cmd_fire) begin
            remain_q <= i_cmd.length;
            state_q  <= (i_cmd.kind == corebus_pkg::CMD_READ) ? ST_READ : ST_WRITE;
          end
        end
        ST_READ: begin
          if (rd_fire) begin
            remain_q <= remain_q - corebus_pkg::length_t'(1);
            if (o_resp.last) begin
              state_q <= ST_IDLE;
            end
          end
        end
        ST_WRITE: begin
          if (wr_fire) begin
            remain_q <= remain_q - corebus_pkg::length_t'(1);
            if (i_wdata.last) begin
              state_q <= ST_IDLE;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (cmd_fire) begin
      id_q   <= i_cmd.id;
      word_q <= i_cmd.addr[`BRIDGE_ADDR_W-1:2];
    end else if (rd_fire || wr_fire) begin
      word_q <= word_q + WORD_W'(1);
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_fire && in_range) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (i_wdata.byteen[b]) begin
          mem[mem_idx][8*b +: 8] <= i_wdata.data[8*b +: 8];
        end
      end
    end
  end

  a_wlast_on_final: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    wr_fire |-> (i_wdata.last == (remain_q == corebus_pkg::length_t'(1))));

endmodule

// ==== src/write_resp_tracker.sv ====
// --------------------------------------------------
// B channel in AW order; bresp is always OKAY.
// --------------------------------------------------
`timescale 1ns/100ps
`include "bridge_macros.svh"

module write_resp_tracker (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_aw_fire,
  input  axi_pkg::id_t         i_aw_id,
  output logic                 o_aw_block,
  input  logic                 i_w_valid,
  output logic                 o_w_ready,
  input  axi_pkg::w_t          i_w,
  output logic                 o_wdata_valid,
  input  logic                 i_wdata_ready,
  output corebus_pkg::wdata_t  o_wdata,
  output logic                 o_b_valid,
  input  logic                 i_b_ready,
  output axi_pkg::b_t          o_b
);

  localparam int DEPTH = `BRIDGE_BID_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  axi_pkg::id_t     id_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] id_cnt_q;
  logic [CNT_W-1:0] done_cnt_q;
  logic             done_full;
  logic             w_last_fire;
  logic             b_fire;

  always_comb begin
    done_full     = (done_cnt_q == CNT_W'(DEPTH));
    o_aw_block    = (id_cnt_q == CNT_W'(DEPTH));
    o_wdata_valid = i_w_valid && !done_full;
    o_w_ready     = i_wdata_ready && !done_full;
    o_wdata       = '{data: i_w.data, byteen: i_w.strb, last: i_w.last};
    w_last_fire   = i_w_valid && o_w_ready && i_w.last;
    o_b_valid     = (done_cnt_q != '0) && (id_cnt_q != '0);
    o_b           = '{id: id_mem[rd_ptr_q], resp: axi_pkg::OKAY};
    b_fire        = o_b_valid && i_b_ready;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      id_cnt_q   <= '0;
      done_cnt_q <= '0;
    end else begin
      wr_ptr_q   <= wr_ptr_q + PTR_W'(i_aw_fire);
      rd_ptr_q   <= rd_ptr_q + PTR_W'(b_fire);
      id_cnt_q   <= id_cnt_q + CNT_W'(i_aw_fire) - CNT_W'(b_fire);
      done_cnt_q <= done_cnt_q + CNT_W'(w_last_fire) - CNT_W'(b_fire);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_aw_fire) begin
      id_mem[wr_ptr_q] <= i_aw_id;
    end
  end

  // every completed write has a queued id, and the queue never overfills.
  a_done_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (done_cnt_q <= id_cnt_q) && (id_cnt_q <= CNT_W'(DEPTH)));

endmodule

// ==== src/axi2corebus_bridge_top.sv ====
// --------------------------------------------------
// AXI slave to 256-word SRAM through the command bus.
// --------------------------------------------------
`timescale 1ns/100ps

module axi2corebus_bridge_top (
  input  logic          i_clk,
  input  logic          i_rst_n,
  input  logic          i_ar_valid,
  output logic          o_ar_ready,
  input  axi_pkg::ax_t  i_ar,
  input  logic          i_aw_valid,
  output logic          o_aw_ready,
  input  axi_pkg::ax_t  i_aw,
  input  logic          i_w_valid,
  output logic          o_w_ready,
  input  axi_pkg::w_t   i_w,
  output logic          o_r_valid,
  input  logic          i_r_ready,
  output axi_pkg::r_t   o_r,
  output logic          o_b_valid,
  input  logic          i_b_ready,
  output axi_pkg::b_t   o_b
);

  logic                cmd_valid;
  logic                cmd_ready;
  corebus_pkg::cmd_t   cmd;
  logic                aw_fire;
  logic                aw_block;
  logic                wdata_valid;
  logic                wdata_ready;
  corebus_pkg::wdata_t wdata;
  corebus_pkg::resp_t  resp;

  axi_cmd_decode u_decode (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_ar_valid (i_ar_valid),
    .o_ar_ready (o_ar_ready),
    .i_ar       (i_ar),
    .i_aw_valid (i_aw_valid),
    .o_aw_ready (o_aw_ready),
    .i_aw       (i_aw),
    .i_aw_block (aw_block),
    .o_aw_fire  (aw_fire),
    .o_cmd_valid(cmd_valid),
    .i_cmd_ready(cmd_ready),
    .o_cmd      (cmd)
  );

  corebus_mem_target u_target (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_cmd_valid  (cmd_valid),
    .o_cmd_ready  (cmd_ready),
    .i_cmd        (cmd),
    .i_wdata_valid(wdata_valid),
    .o_wdata_ready(wdata_ready),
    .i_wdata      (wdata),
    .o_resp_valid (o_r_valid),
    .i_resp_ready (i_r_ready),
    .o_resp       (resp)
  );

  write_resp_tracker u_tracker (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_aw_fire    (aw_fire),
    .i_aw_id      (i_aw.id),
    .o_aw_block   (aw_block),
    .i_w_valid    (i_w_valid),
    .o_w_ready    (o_w_ready),
    .i_w          (i_w),
    .o_wdata_valid(wdata_valid),
    .i_wdata_ready(wdata_ready),
    .o_wdata      (wdata),
    .o_b_valid    (o_b_valid),
    .i_b_ready    (i_b_ready),
    .o_b          (o_b)
  );

  // read responses go straight out as R beats.
  assign o_r.id   = resp.id;
  assign o_r.data = resp.data;
  assign o_r.resp = resp.error ? axi_pkg::SLVERR : axi_pkg::OKAY;
  assign o_r.last = resp.last;

endmodule

// ==== tests/tb_clock.sv ====
// --------------------------------------------------
// free-running clock, reset low for RESET_CYCLES edges.
// --------------------------------------------------
`timescale 1ns/100ps

module tb_clock #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 10
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // release just after an edge so the DUT sees a clean deassertion.
  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1;
    o_rst_n = 1'b1;
  end

endmodule

// ==== tests/bridge_tb.sv ====
// --------------------------------------------------
// directed tests of the AXI bridge against a memory model.
// Reads only touch words that a test has written first.
// --------------------------------------------------
`timescale 1ns/100ps
`include "bridge_macros.svh"

module bridge_tb;

  // the whole sequence needs a few hundred cycles, so this leaves ample margin.
  localparam int CYCLE_LIMIT = 3000;
  localparam int IDX_W       = $clog2(`BRIDGE_MEM_WORDS);

  logic         clk;
  logic         rst_n;
  logic         ar_valid;
  logic         ar_ready;
  axi_pkg::ax_t ar;
  logic         aw_valid;
  logic         aw_ready;
  axi_pkg::ax_t aw;
  logic         w_valid;
  logic         w_ready;
  axi_pkg::w_t  w;
  logic         r_valid;
  logic         r_ready;
  axi_pkg::r_t  r;
  logic         b_valid;
  logic         b_ready;
  axi_pkg::b_t  b;

  logic [31:0] lcg_state;
  logic [31:0] model_mem [`BRIDGE_MEM_WORDS];
  logic [31:0] wbuf [16];
  logic [3:0]  sbuf [16];
  int          cycle_cnt = 0;

  tb_clock #(.PERIOD_NS(4), .RESET_CYCLES(10)) u_clock (.o_clk(clk), .o_rst_n(rst_n));

  axi2corebus_bridge_top axi2corebus_bridge_top_i (
    .i_clk     (clk),
    .i_rst_n   (rst_n),
    .i_ar_valid(ar_valid),
    .o_ar_ready(ar_ready),
    .i_ar      (ar),
    .i_aw_valid(aw_valid),
    .o_aw_ready(aw_ready),
    .i_aw      (aw),
    .i_w_valid (w_valid),
    .o_w_ready (w_ready),
    .i_w       (w),
    .o_r_valid (r_valid),
    .i_r_ready (r_ready),
    .o_r       (r),
    .o_b_valid (b_valid),
    .i_b_ready (b_ready),
    .o_b       (b)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $fatal(1, "simulation timeout");
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // inputs change one ns after the rising edge, outputs are sampled at the falling edge.
  task automatic next_edge();
    @(posedge clk);
    #1;
  endtask

  task automatic model_write(input logic [29:0] word, input logic [31:0] data,
                             input logic [3:0] strb);
    if (word < 30'(`BRIDGE_MEM_WORDS)) begin
      for (int i = 0; i < 4; i++) begin
        if (strb[i]) begin
          model_mem[word[IDX_W-1:0]][8*i +: 8] = data[8*i +: 8];
        end
      end
    end
  endtask

  task automatic prep_data(input axi_pkg::addr_t addr, input int n, input logic rand_strb);
    logic [31:0] rnd;
    for (int i = 0; i < n; i++) begin
      wbuf[i] = lcg_next();
      rnd     = lcg_next();
      sbuf[i] = rand_strb ? rnd[19:16] : 4'hF;
      model_write(addr[31:2] + 30'(i), wbuf[i], sbuf[i]);
    end
  endtask

  task automatic drive_aw(input axi_pkg::id_t id, input axi_pkg::addr_t addr, input int n);
    aw_valid = 1'b1;
    aw       = '{id: id, addr: addr, len: axi_pkg::len_t'(n - 1)};
  endtask

  task automatic finish_aw();
    do begin
      @(negedge clk);
    end while (!aw_ready);
    next_edge();
    aw_valid = 1'b0;
  endtask

  task automatic send_w(input int n);
    for (int i = 0; i < n; i++) begin
      w_valid = 1'b1;
      w       = '{data: wbuf[i], strb: sbuf[i], last: (i == n - 1)};
      do begin
        @(negedge clk);
      end while (!w_ready);
      next_edge();
    end
    w_valid = 1'b0;
  endtask

  task automatic recv_b(input axi_pkg::id_t exp_id);
    b_ready = 1'b1;
    do begin
      @(negedge clk);
    end while (!b_valid);
    check_eq(32'(b.id), 32'(exp_id), "bid");
    check_eq(32'(b.resp), 32'(axi_pkg::OKAY), "bresp");
    next_edge();
    b_ready = 1'b0;
  endtask

  task automatic write_burst(input axi_pkg::id_t id, input axi_pkg::addr_t addr, input int n,
                             input logic rand_strb, input logic wait_b);
    prep_data(addr, n, rand_strb);
    drive_aw(id, addr, n);
    finish_aw();
    send_w(n);
    if (wait_b) begin
      recv_b(id);
    end
  endtask

  task automatic read_burst(input axi_pkg::id_t id, input axi_pkg::addr_t addr, input int n,
                            input logic toggle);
    logic [29:0] word;
    logic [31:0] rnd;
    logic        in_range;
    int          beat;
    ar_valid = 1'b1;
    ar       = '{id: id, addr: addr, len: axi_pkg::len_t'(n - 1)};
    do begin
      @(negedge clk);
    end while (!ar_ready);
    next_edge();
    ar_valid = 1'b0;
    beat     = 0;
    while (beat < n) begin
      rnd     = lcg_next();
      r_ready = toggle ? rnd[16] : 1'b1;
      @(negedge clk);
      if (r_valid && r_ready) begin
        word     = addr[31:2] + 30'(beat);
        in_range = word < 30'(`BRIDGE_MEM_WORDS);
        check_eq(32'(r.id), 32'(id), "rid");
        check_eq(32'(r.last), 32'(beat == n - 1), "rlast");
        check_eq(32'(r.resp), in_range ? 32'(axi_pkg::OKAY) : 32'(axi_pkg::SLVERR), "rresp");
        if (in_range) begin
          check_eq(r.data, model_mem[word[IDX_W-1:0]], "rdata");
        end
        beat++;
      end
      next_edge();
    end
    r_ready = 1'b0;
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic test_single();
    write_burst(4'h3, 32'h10, 1, 1'b0, 1'b1);
    read_burst(4'h5, 32'h10, 1, 1'b0);
  endtask

  task automatic test_burst();
    // full-strobe fill first so that partial strobes land on known bytes.
    write_burst(4'h1, 32'h40, 8, 1'b0, 1'b1);
    write_burst(4'h2, 32'h40, 8, 1'b1, 1'b1);
    read_burst(4'h3, 32'h40, 8, 1'b1);
  endtask

  task automatic test_out_of_range();
    read_burst(4'h6, 32'(`BRIDGE_MEM_WORDS * 4), 4, 1'b0);
    // word index 4 above the limit would alias the word written by test_single.
    write_burst(4'h7, 32'((`BRIDGE_MEM_WORDS + 4) * 4), 2, 1'b0, 1'b1);
    read_burst(4'h8, 32'h10, 1, 1'b0);
  endtask

  task automatic test_unaligned();
    write_burst(4'h9, 32'h81, 2, 1'b0, 1'b1);
    read_burst(4'hA, 32'h83, 2, 1'b0);
    read_burst(4'hB, 32'h86, 1, 1'b0);
  endtask

  task automatic test_b_backpressure();
    for (int i = 0; i < 4; i++) begin
      write_burst(axi_pkg::id_t'(12 + i), 32'h100 + 32'(4 * i), 1, 1'b0, 1'b0);
    end
    prep_data(32'h110, 1, 1'b0);
    drive_aw(4'h1, 32'h110, 1);
    repeat (6) begin
      @(negedge clk);
      check_eq(32'(aw_ready), 32'd0, "awready with four B pending");
      check_eq(32'(b_valid), 32'd1, "bvalid held under bready low");
    end
    next_edge();
    recv_b(4'hC);
    finish_aw();
    send_w(1);
    recv_b(4'hD);
    recv_b(4'hE);
    recv_b(4'hF);
    recv_b(4'h1);
    read_burst(4'h2, 32'h100, 5, 1'b1);
  endtask

  task automatic test_concurrent();
    for (int k = 0; k < 3; k++) begin
      fork
        read_burst(axi_pkg::id_t'(k), 32'h40, 8, 1'b0);
        write_burst(axi_pkg::id_t'(8 + k), 32'h200 + 32'(16 * k), 4, 1'b0, 1'b1);
      join
    end
    read_burst(4'h4, 32'h200, 12, 1'b0);
  endtask

  initial begin
    lcg_state = 32'h87ce2c66;
    ar_valid  = 1'b0;
    ar        = '0;
    aw_valid  = 1'b0;
    aw        = '0;
    w_valid   = 1'b0;
    w         = '0;
    r_ready   = 1'b0;
    b_ready   = 1'b0;
    wait (rst_n === 1'b1);
    next_edge();
    test_single();
    test_burst();
    test_out_of_range();
    test_unaligned();
    test_b_backpressure();
    test_concurrent();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+src
src/axi_pkg.sv
src/corebus_pkg.sv
src/axi_cmd_decode.sv
src/corebus_mem_target.sv
src/write_resp_tracker.sv
src/axi2corebus_bridge_top.sv
tests/tb_clock.sv
tests/bridge_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the bridge testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module bridge_tb \
  -f list.f \
  -o bridge_sim

# tee keeps the pipeline status zero, so the log decides the result.
./obj_dir/bridge_sim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
grep -q "STATUS: PASS" sim.log
